/* logic/ptw_pkg.sv */
package ptw_pkg;

	// ==============================
	// Widths and sizes
	// ==============================

	localparam int VADR_W = 32;
	localparam int PADR_W = 32;
	localparam int ASID_W = 8;
	localparam int PPN_W = 20;
	localparam int PTE_W = 64;
	localparam int PERM_W = 4;
	localparam int MISSQ_SIZE = 8;
	localparam int QIDX_W = $clog2(MISSQ_SIZE);
	localparam int TRANBUF_SIZE = 16;
	localparam int TID_W = 4;
	localparam int MEM_CREDITS_MAX = 4;
	// The counter must be able to hold MEM_CREDITS_MAX itself
	localparam int MEM_CREDIT_W = $clog2(MEM_CREDITS_MAX + 1);

	// ==============================
	// Request and queue types
	// ==============================

	typedef struct packed {
		logic [ASID_W-1:0] asid;
		logic [VADR_W-1:0] vadr;
	} ptw_miss_req_t;

	// Level 1 is the root directory, level 0 holds the 4 KiB pages
	typedef struct packed {
		logic v;
		logic inflight;
		logic lvl;
		logic [ASID_W-1:0] asid;
		logic [VADR_W-1:0] vadr;
		logic [PPN_W-1:0] base;
	} ptw_miss_entry_t;

	typedef struct packed {
		logic [TID_W-1:0] tid;
		logic [PADR_W-1:0] padr;
	} ptw_mem_req_t;

	typedef struct packed {
		logic ack;
		logic [TID_W-1:0] tid;
		logic [127:0] dat;
	} ptw_mem_resp_t;

	// ==============================
	// Page table entry
	// ==============================

	// Valid sits in bit 0 and the leaf flag in bit 1 for both views
	typedef struct packed {
		logic [31:0] rsvd_hi;
		logic [PPN_W-1:0] ppn;
		logic [5:0] rsvd;
		logic [PERM_W-1:0] perm;
		logic is_leaf;
		logic v;
	} ptw_pte_leaf_t;

	typedef struct packed {
		logic [31:0] rsvd_hi;
		logic [PPN_W-1:0] ntp;
		logic [9:0] rsvd;
		logic is_leaf;
		logic v;
	} ptw_pte_dir_t;

	typedef union packed {
		ptw_pte_leaf_t leaf;
		ptw_pte_dir_t dir;
	} ptw_pte_t;

	typedef struct packed {
		logic v;
		logic rdy;
		logic [TID_W-1:0] tid;
		logic [QIDX_W-1:0] qidx;
		logic [PADR_W-1:0] padr;
		ptw_pte_t pte;
	} ptw_tran_buf_t;

	typedef struct packed {
		logic [ASID_W-1:0] asid;
		logic [PPN_W-1:0] vpn;
		logic [PPN_W-1:0] ppn;
		logic [PERM_W-1:0] perm;
		logic fault;
	} tlb_update_t;

endpackage

/* logic/ptw_miss_queue.sv */
`timescale 1ns/1ps

module ptw_miss_queue (
	input logic clk,
	input logic rst,
	input logic miss_valid,
	input ptw_pkg::ptw_miss_req_t miss_req,
	input logic [ptw_pkg::PPN_W-1:0] root_base,
	input logic issue,
	input logic step_valid,
	input logic [ptw_pkg::QIDX_W-1:0] step_idx,
	input logic [ptw_pkg::PPN_W-1:0] step_base,
	input logic retire_valid,
	input logic [ptw_pkg::QIDX_W-1:0] retire_idx,
	output ptw_pkg::ptw_miss_entry_t [ptw_pkg::MISSQ_SIZE-1:0] entries,
	output logic [ptw_pkg::QIDX_W-1:0] sel_qe,
	output logic sel_none,
	output logic [ptw_pkg::PADR_W-1:0] ent_padr
);

	import ptw_pkg::*;

	logic [QIDX_W-1:0] free_idx;
	logic free_none;
	ptw_miss_entry_t sel_ent;
	logic [9:0] vidx;

	// ==============================
	// Entry selection
	// ==============================

	// Lowest free entry takes the next miss
	// The requester's credits keep the queue from overflowing, but a miss
	// that finds no room is dropped rather than overwriting a live entry
	always_comb begin
		free_idx = '0;
		free_none = 1'b1;
		for (int i = MISSQ_SIZE - 1; i >= 0; i--) begin
			if (!entries[i].v) begin
				free_idx = QIDX_W'(i);
				free_none = 1'b0;
			end
		end
	end

	// Lowest valid entry with no read outstanding goes out next
	always_comb begin
		sel_qe = '0;
		sel_none = 1'b1;
		for (int i = MISSQ_SIZE - 1; i >= 0; i--) begin
			if (entries[i].v && !entries[i].inflight) begin
				sel_qe = QIDX_W'(i);
				sel_none = 1'b0;
			end
		end
	end

	// ==============================
	// Entry address
	// ==============================

	// Each level consumes ten bits of the virtual page number
	assign sel_ent = entries[sel_qe];
	assign vidx = sel_ent.lvl ? sel_ent.vadr[31:22] : sel_ent.vadr[21:12];

	// Table base is a page number, entries are eight bytes wide
	assign ent_padr = {sel_ent.base, 12'h000} + {{(PADR_W - 13){1'b0}}, vidx, 3'b000};

	// ==============================
	// Queue state
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < MISSQ_SIZE; i++) begin
				entries[i].v <= 1'b0;
				entries[i].inflight <= 1'b0;
			end
		end else begin
			// A fresh miss always starts from the root directory
			if (miss_valid && !free_none) begin
				entries[free_idx].v <= 1'b1;
				entries[free_idx].inflight <= 1'b0;
				entries[free_idx].lvl <= 1'b1;
				entries[free_idx].asid <= miss_req.asid;
				entries[free_idx].vadr <= miss_req.vadr;
				entries[free_idx].base <= root_base;
			end

			// The buffer took the selected entry's read this cycle
			if (issue)
				entries[sel_qe].inflight <= 1'b1;

			// Directory hit at level 1, so walk on into the next table
			if (step_valid) begin
				entries[step_idx].lvl <= 1'b0;
				entries[step_idx].base <= step_base;
				entries[step_idx].inflight <= 1'b0;
			end

			// Walk finished, the entry becomes free for a new miss
			if (retire_valid) begin
				entries[retire_idx].v <= 1'b0;
				entries[retire_idx].inflight <= 1'b0;
			end
		end
	end

endmodule

/* logic/ptw_tran_buffer.sv */
`timescale 1ns/1ps

module ptw_tran_buffer (
	input logic clk,
	input logic rst,
	input logic [ptw_pkg::QIDX_W-1:0] sel_qe,
	input logic sel_none,
	input logic [ptw_pkg::PADR_W-1:0] ent_padr,
	input logic mem_credit,
	input ptw_pkg::ptw_mem_resp_t mem_resp,
	input logic [ptw_pkg::TID_W-1:0] sel_tran,
	input logic sel_tran_none,
	output ptw_pkg::ptw_tran_buf_t [ptw_pkg::TRANBUF_SIZE-1:0] tranbuf,
	output logic issue,
	output logic mem_req_valid,
	output ptw_pkg::ptw_mem_req_t mem_req
);

	import ptw_pkg::*;

	logic [TID_W-1:0] next_tid;
	logic [MEM_CREDIT_W-1:0] mem_cred;
	logic resp_hit;
	ptw_tran_buf_t resp_slot;

	// A read goes out only with a credit in hand and the id's slot idle
	// Slot index and transaction id are the same number
	assign issue = !sel_none && (mem_cred != '0) && !tranbuf[next_tid].v;

	// ==============================
	// Response matching
	// ==============================

	// Id 0 is never handed out, so it can never match a live slot
	// The slot must also still be waiting, otherwise the response is stale
	assign resp_slot = tranbuf[mem_resp.tid];
	assign resp_hit = mem_resp.ack && (mem_resp.tid != '0) &&
		(mem_resp.tid == resp_slot.tid) && resp_slot.v && !resp_slot.rdy;

	// ==============================
	// Credits, ids and request port
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			next_tid <= TID_W'(1);
			mem_cred <= '0;
			mem_req_valid <= 1'b0;
		end else begin
			// Credit returns and spends may land on the same edge
			mem_cred <= mem_cred + MEM_CREDIT_W'(mem_credit) - MEM_CREDIT_W'(issue);
			mem_req_valid <= issue;
			if (issue) begin
				// Ids run 1 to 15 and then wrap back to 1
				if (&next_tid)
					next_tid <= TID_W'(1);
				else
					next_tid <= next_tid + TID_W'(1);
			end
		end
	end

	// Request payload follows mem_req_valid
	always_ff @(posedge clk) begin
		if (issue) begin
			mem_req.tid <= next_tid;
			mem_req.padr <= ent_padr;
		end
	end

	// ==============================
	// Slot state
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < TRANBUF_SIZE; i++) begin
				tranbuf[i].v <= 1'b0;
				tranbuf[i].rdy <= 1'b0;
			end
		end else begin
			// Record the outstanding read against its queue entry
			if (issue) begin
				tranbuf[next_tid].v <= 1'b1;
				tranbuf[next_tid].rdy <= 1'b0;
				tranbuf[next_tid].tid <= next_tid;
				tranbuf[next_tid].qidx <= sel_qe;
				tranbuf[next_tid].padr <= ent_padr;
			end

			// Address bit 3 picks which half of the 128-bit word holds the entry
			if (resp_hit) begin
				tranbuf[mem_resp.tid].pte <= resp_slot.padr[3] ? mem_resp.dat[127:64]
					: mem_resp.dat[63:0];
				tranbuf[mem_resp.tid].rdy <= 1'b1;
			end

			// Resolver consumed this slot
			if (!sel_tran_none) begin
				tranbuf[sel_tran].v <= 1'b0;
				tranbuf[sel_tran].rdy <= 1'b0;
			end
		end
	end

endmodule

/* logic/ptw_resolver.sv */
`timescale 1ns/1ps

module ptw_resolver (
	input logic clk,
	input logic rst,
	input ptw_pkg::ptw_tran_buf_t [ptw_pkg::TRANBUF_SIZE-1:0] tranbuf,
	input ptw_pkg::ptw_miss_entry_t [ptw_pkg::MISSQ_SIZE-1:0] entries,
	output logic [ptw_pkg::TID_W-1:0] sel_tran,
	output logic sel_tran_none,
	output logic step_valid,
	output logic [ptw_pkg::QIDX_W-1:0] step_idx,
	output logic [ptw_pkg::PPN_W-1:0] step_base,
	output logic retire_valid,
	output logic [ptw_pkg::QIDX_W-1:0] retire_idx,
	output logic miss_credit,
	output logic tlb_valid,
	output ptw_pkg::tlb_update_t tlb_update
);

	import ptw_pkg::*;

	ptw_tran_buf_t slot;
	ptw_pte_t pte;
	ptw_miss_entry_t ent;
	logic do_step;
	tlb_update_t upd;

	// ==============================
	// Slot pick
	// ==============================

	// One slot per cycle, lowest index wins
	always_comb begin
		sel_tran = '0;
		sel_tran_none = 1'b1;
		for (int i = TRANBUF_SIZE - 1; i >= 0; i--) begin
			if (tranbuf[i].v && tranbuf[i].rdy) begin
				sel_tran = TID_W'(i);
				sel_tran_none = 1'b0;
			end
		end
	end

	assign slot = tranbuf[sel_tran];
	assign pte = slot.pte;
	assign ent = entries[slot.qidx];

	// ==============================
	// Entry decode
	// ==============================

	// Valid and leaf flags sit at the same place in both views
	always_comb begin
		do_step = 1'b0;
		upd.asid = ent.asid;
		upd.vpn = ent.vadr[31:12];
		upd.ppn = '0;
		upd.perm = '0;
		upd.fault = 1'b1;
		if (pte.leaf.v && pte.leaf.is_leaf) begin
			upd.fault = 1'b0;
			upd.perm = pte.leaf.perm;
			// A level 1 leaf maps 4 MiB, so the low ten page bits come from the VA
			if (ent.lvl)
				upd.ppn = {pte.leaf.ppn[PPN_W-1:10], ent.vadr[21:12]};
			else
				upd.ppn = pte.leaf.ppn;
		end else if (pte.dir.v && ent.lvl) begin
			do_step = 1'b1;
		end
		// Anything else is a fault, either an invalid entry or a directory at level 0
	end

	// Commands reach the miss queue on the edge that frees the slot
	assign step_valid = !sel_tran_none && do_step;
	assign step_idx = slot.qidx;
	assign step_base = pte.dir.ntp;
	assign retire_valid = !sel_tran_none && !do_step;
	assign retire_idx = slot.qidx;

	// ==============================
	// TLB update and credit return
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			tlb_valid <= 1'b0;
			miss_credit <= 1'b0;
		end else begin
			// Every finished walk frees a queue entry and hands back one credit
			tlb_valid <= retire_valid;
			miss_credit <= retire_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (retire_valid)
			tlb_update <= upd;
	end

endmodule

/* logic/ptw_top.sv */
`timescale 1ns/1ps

module ptw_top (
	input logic clk,
	input logic rst,
	input logic miss_valid,
	input ptw_pkg::ptw_miss_req_t miss_req,
	output logic miss_credit,
	output logic mem_req_valid,
	output ptw_pkg::ptw_mem_req_t mem_req,
	input logic mem_credit,
	input ptw_pkg::ptw_mem_resp_t mem_resp,
	output logic tlb_valid,
	output ptw_pkg::tlb_update_t tlb_update,
	input logic [ptw_pkg::PPN_W-1:0] root_base
);

	import ptw_pkg::*;

	// ==============================
	// Internal wiring
	// ==============================

	// Miss queue to buffer
	ptw_miss_entry_t [MISSQ_SIZE-1:0] entries;
	logic [QIDX_W-1:0] sel_qe;
	logic sel_none;
	logic [PADR_W-1:0] ent_padr;
	logic issue;

	// Buffer to resolver
	ptw_tran_buf_t [TRANBUF_SIZE-1:0] tranbuf;
	logic [TID_W-1:0] sel_tran;
	logic sel_tran_none;

	// Resolver back to the miss queue
	logic step_valid;
	logic [QIDX_W-1:0] step_idx;
	logic [PPN_W-1:0] step_base;
	logic retire_valid;
	logic [QIDX_W-1:0] retire_idx;

	// ==============================
	// Instances
	// ==============================

	ptw_miss_queue u_miss_queue (
		.clk(clk),
		.rst(rst),
		.miss_valid(miss_valid),
		.miss_req(miss_req),
		.root_base(root_base),
		.issue(issue),
		.step_valid(step_valid),
		.step_idx(step_idx),
		.step_base(step_base),
		.retire_valid(retire_valid),
		.retire_idx(retire_idx),
		.entries(entries),
		.sel_qe(sel_qe),
		.sel_none(sel_none),
		.ent_padr(ent_padr)
	);

	ptw_tran_buffer u_tran_buffer (
		.clk(clk),
		.rst(rst),
		.sel_qe(sel_qe),
		.sel_none(sel_none),
		.ent_padr(ent_padr),
		.mem_credit(mem_credit),
		.mem_resp(mem_resp),
		.sel_tran(sel_tran),
		.sel_tran_none(sel_tran_none),
		.tranbuf(tranbuf),
		.issue(issue),
		.mem_req_valid(mem_req_valid),
		.mem_req(mem_req)
	);

	ptw_resolver u_resolver (
		.clk(clk),
		.rst(rst),
		.tranbuf(tranbuf),
		.entries(entries),
		.sel_tran(sel_tran),
		.sel_tran_none(sel_tran_none),
		.step_valid(step_valid),
		.step_idx(step_idx),
		.step_base(step_base),
		.retire_valid(retire_valid),
		.retire_idx(retire_idx),
		.miss_credit(miss_credit),
		.tlb_valid(tlb_valid),
		.tlb_update(tlb_update)
	);

endmodule

/* test/ptw_sva.sv */
`timescale 1ns/1ps

module ptw_sva (
	input logic clk,
	input logic rst,
	input logic mem_credit,
	input logic mem_req_valid,
	input ptw_pkg::ptw_mem_req_t mem_req
);

	import ptw_pkg::*;

	logic [MEM_CREDIT_W-1:0] avail;
	logic [TID_W-1:0] prev_tid;
	logic seen_req;

	// ==============================
	// Port-side bookkeeping
	// ==============================

	// Credits seen on the port less requests seen on the port
	// Last id that went out, for the sequence check
	always_ff @(posedge clk) begin
		if (rst) begin
			avail <= '0;
			seen_req <= 1'b0;
		end else begin
			avail <= avail + MEM_CREDIT_W'(mem_credit) - MEM_CREDIT_W'(mem_req_valid);
			if (mem_req_valid) begin
				prev_tid <= mem_req.tid;
				seen_req <= 1'b1;
			end
		end
	end

	// ==============================
	// Credit and id rules
	// ==============================

	// A request on the port must be covered by a credit already granted
	req_needs_credit: assert property (@(posedge clk) disable iff (rst)
		mem_req_valid |-> avail != '0) else $error("memory request with no credit left");

	// Ids follow each other on the port, and the last id wraps back to 1
	tid_in_order: assert property (@(posedge clk) disable iff (rst)
		mem_req_valid && seen_req |->
			mem_req.tid == ((&prev_tid) ? TID_W'(1) : prev_tid + TID_W'(1)))
		else $error("transaction id out of sequence");

	// Requests on the port always carry a live id
	req_tid_nonzero: assert property (@(posedge clk) disable iff (rst)
		mem_req_valid |-> mem_req.tid != '0) else $error("memory request with id 0");

endmodule

bind ptw_tran_buffer ptw_sva u_sva (
	.clk(clk),
	.rst(rst),
	.mem_credit(mem_credit),
	.mem_req_valid(mem_req_valid),
	.mem_req(mem_req)
);

/* test/ptw_tb.sv */
`timescale 1ns/1ps

module ptw_tb;

	import ptw_pkg::*;

	localparam logic [19:0] ROOT = 20'h00100;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic miss_valid = 1'b0;
	ptw_miss_req_t miss_req = '0;
	logic miss_credit;
	logic mem_req_valid;
	ptw_mem_req_t mem_req;
	logic mem_credit = 1'b0;
	ptw_mem_resp_t mem_resp = '0;
	logic tlb_valid;
	tlb_update_t tlb_update;

	logic [15:0] lfsr = 16'd11134;
	int cyc = 0;
	int val_errs = 0;
	int other_errs = 0;
	int done_cnt = 0;
	int req_cnt = 0;
	int grant_cnt = 0;
	int owed = 0;
	int req_credits = MISSQ_SIZE;
	int credit_cnt = 0;
	int sent_cnt = 0;
	logic credit_hold = 1'b1;
	logic resp_hold = 1'b0;
	logic inject_pending = 1'b0;
	logic [TID_W-1:0] inject_tid = '0;
	logic [TID_W-1:0] exp_tid = 1;
	logic [TID_W-1:0] last_tid = '0;
	logic [7:0] asid_ctr = 8'd1;
	tlb_update_t exp_q[$];
	logic [TID_W-1:0] rq_tid[$];
	logic [PADR_W-1:0] rq_padr[$];
	int rq_due[$];

	ptw_top uut (.clk(clk), .rst(rst), .miss_valid(miss_valid), .miss_req(miss_req),
		.miss_credit(miss_credit), .mem_req_valid(mem_req_valid), .mem_req(mem_req),
		.mem_credit(mem_credit), .mem_resp(mem_resp), .tlb_valid(tlb_valid),
		.tlb_update(tlb_update), .root_base(ROOT));

	always #2 clk = ~clk;

	// ==============================
	// Helpers
	// ==============================

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// Table contents as a fixed function of the entry address
	// Root entries cycle through directory, directory, superpage and invalid
	// Level 0 entries are leaves except index 6 (invalid) and 7 (directory)
	function automatic logic [63:0] pte_for(input logic [31:0] a);
		logic [9:0] idx;
		logic [63:0] p;
		idx = a[12:3];
		p = '0;
		p[63:32] = a ^ 32'h5a5a0000;
		p[5:2] = a[6:3] ^ a[16:13];
		p[31:12] = a[31:12] ^ {idx, idx};
		if (a[31:13] == ROOT[19:1]) begin
			p[0] = (idx[1:0] != 2'd3);
			p[1] = (idx[1:0] == 2'd2);
			if (idx[1] == 1'b0)
				p[31:12] = 20'h40000 + {idx, 1'b0};
		end else begin
			p[0] = (idx[2:0] != 3'd6);
			p[1] = (idx[2:0] != 3'd7);
		end
		return p;
	endfunction

	// Expected result of a walk from the root table
	function automatic tlb_update_t ref_walk(input logic [7:0] asid, input logic [31:0] va);
		tlb_update_t u;
		logic [63:0] p;
		u = '0;
		u.asid = asid;
		u.vpn = va[31:12];
		u.fault = 1'b1;
		p = pte_for({ROOT, 12'h0} + {va[31:22], 3'b000});
		if (p[0] && p[1]) begin
			u.fault = 1'b0;
			u.perm = p[5:2];
			u.ppn = {p[31:22], va[21:12]};
		end else if (p[0]) begin
			p = pte_for({p[31:12], 12'h0} + {va[21:12], 3'b000});
			if (p[0] && p[1]) begin
				u.fault = 1'b0;
				u.perm = p[5:2];
				u.ppn = p[31:12];
			end
		end
		return u;
	endfunction

	task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
			val_errs++;
		end
	endtask

	task automatic timeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("*** FAILED ***");
		$finish;
	endtask

	// Requester side, one miss per cycle while credits last
	task automatic send_miss(input logic [31:0] va);
		int t;
		t = 0;
		@(posedge clk);
		#1;
		while (req_credits == 0) begin
			miss_valid = 1'b0;
			@(posedge clk);
			#1;
			if (++t > 500)
				timeout("a miss credit");
		end
		miss_valid = 1'b1;
		miss_req.asid = asid_ctr;
		miss_req.vadr = va;
		exp_q.push_back(ref_walk(asid_ctr, va));
		asid_ctr++;
		req_credits--;
		sent_cnt++;
	endtask

	task automatic end_misses();
		@(posedge clk);
		#1;
		miss_valid = 1'b0;
	endtask

	task automatic wait_done(input int n);
		int t;
		t = 0;
		while (done_cnt < n) begin
			@(posedge clk);
			if (++t > 2000)
				timeout("TLB updates");
		end
	endtask

	task automatic inject(input logic [TID_W-1:0] tid);
		int t;
		t = 0;
		inject_tid = tid;
		inject_pending = 1'b1;
		while (inject_pending) begin
			@(posedge clk);
			if (++t > 20)
				timeout("a stale response slot");
		end
	endtask

	// ==============================
	// Memory model
	// ==============================

	always begin
		int k;
		logic [31:0] base;
		@(posedge clk);
		#1;
		cyc++;
		mem_credit = 1'b0;
		mem_resp = '0;
		if (!credit_hold && owed > 0) begin
			mem_credit = 1'b1;
			owed--;
			grant_cnt++;
		end
		if (inject_pending) begin
			mem_resp.ack = 1'b1;
			mem_resp.tid = inject_tid;
			mem_resp.dat = {rand_bits(32), rand_bits(32), rand_bits(32), 32'h0000_0003};
			inject_pending = 1'b0;
		end else if (!resp_hold && rq_tid.size() > 0) begin
			// Sometimes answer the second request first
			k = 0;
			if (rq_tid.size() > 1 && rq_due[1] <= cyc && rand_bits(1))
				k = 1;
			if (rq_due[k] <= cyc) begin
				base = rq_padr[k] & ~32'hf;
				mem_resp.ack = 1'b1;
				mem_resp.tid = rq_tid[k];
				mem_resp.dat = {pte_for(base | 32'h8), pte_for(base)};
				rq_tid.delete(k);
				rq_padr.delete(k);
				rq_due.delete(k);
				owed++;
			end
		end
	end

	// ==============================
	// Monitors
	// ==============================

	always @(negedge clk) begin
		int f;
		if (!rst && mem_req_valid) begin
			req_cnt++;
			check("req_tid_seq", exp_tid, mem_req.tid);
			exp_tid = (&exp_tid) ? 1 : exp_tid + 1;
			last_tid = mem_req.tid;
			check("req_within_credits", 1, req_cnt <= grant_cnt);
			rq_tid.push_back(mem_req.tid);
			rq_padr.push_back(mem_req.padr);
			rq_due.push_back(cyc + 1 + int'(rand_bits(3)));
		end
		if (!rst && miss_credit) begin
			req_credits++;
			credit_cnt++;
		end
		// Match each update to its miss by ASID and virtual page
		if (!rst && tlb_valid) begin
			f = -1;
			foreach (exp_q[i])
				if (f < 0 && exp_q[i].asid == tlb_update.asid && exp_q[i].vpn == tlb_update.vpn)
					f = i;
			if (f < 0) begin
				$display("update for asid %h vpn %h matches no outstanding miss",
					tlb_update.asid, tlb_update.vpn);
				other_errs++;
			end else begin
				check("tlb_update", exp_q[f], tlb_update);
				exp_q.delete(f);
			end
			done_cnt++;
		end
	end

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		owed = 2 + int'(rand_bits(2) % 3);
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;

		// Credits withheld, so nothing may reach memory
		send_miss({10'd0, 10'd1, 12'h123});
		end_misses();
		repeat (20) @(posedge clk);
		check("no_req_without_credit", 0, req_cnt);
		credit_hold = 1'b0;
		wait_done(1);
		check("single_walk_credit", 1, credit_cnt);

		// Superpage, root invalid, level 0 directory and level 0 invalid
		send_miss({10'd2, 10'd77, 12'h0});
		send_miss({10'd3, 10'd5, 12'h0});
		send_miss({10'd4, 10'd7, 12'h0});
		send_miss({10'd5, 10'd6, 12'h0});
		end_misses();
		wait_done(5);

		// Full credit of random misses back to back
		for (int i = 0; i < MISSQ_SIZE; i++)
			send_miss(rand_bits(32));
		end_misses();
		wait_done(5 + MISSQ_SIZE);

		// Stale ids while one read is held back
		resp_hold = 1'b1;
		send_miss({10'd2, 10'd9, 12'h0});
		end_misses();
		begin
			int t;
			t = 0;
			while (rq_tid.size() == 0) begin
				@(posedge clk);
				if (++t > 200)
					timeout("the held request");
			end
		end
		inject((last_tid == 1) ? 4'd15 : last_tid - 1);
		inject('0);
		repeat (10) @(posedge clk);
		check("stale_no_update", 6 + MISSQ_SIZE - 1, done_cnt);
		resp_hold = 1'b0;
		wait_done(6 + MISSQ_SIZE);
		repeat (10) @(posedge clk);

		check("all_done", sent_cnt, done_cnt);
		check("credits_returned", sent_cnt, credit_cnt);
		check("ids_wrapped", 1, req_cnt > 15);
		check("no_leftover", 0, exp_q.size());
		$display("errors: %0d value mismatches, %0d other", val_errs, other_errs);
		if (val_errs == 0 && other_errs == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

/* files.f */
logic/ptw_pkg.sv
logic/ptw_miss_queue.sv
logic/ptw_tran_buffer.sv
logic/ptw_resolver.sv
logic/ptw_top.sv
test/ptw_sva.sv
test/ptw_tb.sv

/* Makefile */
SIM := obj_dir/ptw_sim
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f files.f --top-module ptw_tb \
		--Mdir obj_dir -o ptw_sim

run: compile
	./$(SIM) | tee $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG) || { echo "no result in log"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
